//--- nocPkg.sv
package nocPkg;

  // Flit kinds as carried in the id field
  typedef logic [2:0] flitId_t;

  localparam flitId_t FlitHeader = 3'b001;
  localparam flitId_t FlitBody   = 3'b010;
  localparam flitId_t FlitTail   = 3'b100;

  // Hold budget in cycles, low payload bits of a header
  typedef logic [11:0] length_t;

  typedef logic [15:0] payload_t;

  typedef struct packed {
    flitId_t  id;
    payload_t payload;
  } flit_t;

  localparam int numPorts = 5;

  // Local 0, North 1, East 2, West 3, South 4
  typedef logic [2:0] portIdx_t;

  typedef logic [numPorts-1:0] portOneHot_t;

  // Bit 0 is Idle, bit i+1 is the grant of input i
  typedef enum logic [5:0] {
    Idle   = 6'b000001,
    GrantL = 6'b000010,
    GrantN = 6'b000100,
    GrantE = 6'b001000,
    GrantW = 6'b010000,
    GrantS = 6'b100000
  } arbState_t;

  // Output link word
  typedef struct packed {
    flit_t    flit;
    portIdx_t src;
  } linkFlit_t;

endpackage

//--- flitFifo.sv
`timescale 1ns/100ps

module flitFifo #(
  parameter int FifoDepth = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t wrFlit,
  input  logic          wr,
  input  logic          pop,
  output nocPkg::flit_t head,
  output logic          notEmpty,
  output logic          overflow
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);

  nocPkg::flit_t mem [FifoDepth];

  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [CntW-1:0] count;
  logic            full;
  logic            doWr;

  // Wrap at the last entry, any depth
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    if (ptr == PtrW'(FifoDepth - 1))
    begin
      nxt = '0;
    end
    else
    begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full     = (count == CntW'(FifoDepth));
  assign doWr     = wr && !full;
  assign notEmpty = (count != '0);
  assign head     = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWr)
    begin
      mem[wrPtr] <= wrFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr    <= '0;
      wrPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (doWr)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({doWr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky, flit is lost
      if (wr && full)
      begin
        overflow <= 1'b1;
      end
    end
  end

  popWhileEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
    else $error("flitFifo: pop while empty");

  writeWhileFull: assert property (@(posedge clk) disable iff (rst) wr |-> !full)
    else $error("flitFifo: write while full, flit dropped");

endmodule

//--- holdTimer.sv
`timescale 1ns/100ps

module holdTimer (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t head,
  input  logic          popped,
  input  logic          granted,
  output logic          expired
);

  // Length of the latest header popped from this input
  nocPkg::length_t pendingLen;
  // Budget of the running tenure
  nocPkg::length_t budget;
  nocPkg::length_t count;
  logic            headerPop;

  assign headerPop = popped && (head.id == nocPkg::FlitHeader);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pendingLen <= nocPkg::length_t'(1);
      budget     <= nocPkg::length_t'(1);
      count      <= '0;
    end
    else
    begin
      if (headerPop)
      begin
        pendingLen <= nocPkg::length_t'(head.payload);
      end
      // A new header only counts from the next tenure on
      if (!granted)
      begin
        budget <= pendingLen;
        count  <= '0;
      end
      else if (popped)
      begin
        count <= count + 1'b1;
      end
    end
  end

  assign expired = (count == budget);

endmodule

//--- outputArbiter.sv
`timescale 1ns/100ps

module outputArbiter (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocPkg::portOneHot_t                  req,
  input  nocPkg::flit_t [nocPkg::numPorts-1:0] head,
  output nocPkg::portOneHot_t                  pop
);

  nocPkg::arbState_t   state;
  nocPkg::arbState_t   nextState;
  nocPkg::portOneHot_t grantVec;
  nocPkg::portOneHot_t expired;
  logic                hold;

  function automatic nocPkg::arbState_t grantOf(input int idx);
    nocPkg::arbState_t g;
    case (idx)
      0:       g = nocPkg::GrantL;
      1:       g = nocPkg::GrantN;
      2:       g = nocPkg::GrantE;
      3:       g = nocPkg::GrantW;
      4:       g = nocPkg::GrantS;
      default: g = nocPkg::Idle;
    endcase
    return g;
  endfunction

  // First requester in circular order, span ports starting at first
  function automatic nocPkg::arbState_t scanFrom(
    input nocPkg::portOneHot_t r,
    input int                  first,
    input int                  span
  );
    nocPkg::arbState_t pick;
    int                idx;
    logic              found;
    pick  = nocPkg::Idle;
    found = 1'b0;
    for (int k = 0; k < span; k++)
    begin
      idx = (first + k) % nocPkg::numPorts;
      if (!found && r[idx])
      begin
        pick  = grantOf(idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // One-hot state, grant bits sit above Idle
  assign grantVec = state[nocPkg::numPorts:1];

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gTimer
    holdTimer uTimer (
      .clk     (clk),
      .rst     (rst),
      .head    (head[i]),
      .popped  (pop[i]),
      .granted (grantVec[i]),
      .expired (expired[i])
    );
  end

  assign pop  = grantVec & req & ~expired;
  assign hold = |pop;

  always_comb
  begin
    nextState = state;
    case (state)
      // Local first out of Idle
      nocPkg::Idle:
      begin
        nextState = scanFrom(req, 0, nocPkg::numPorts);
      end
      nocPkg::GrantL:
      begin
        if (!hold)
        begin
          nextState = scanFrom(req, 1, nocPkg::numPorts - 1);
        end
      end
      nocPkg::GrantN:
      begin
        if (!hold)
        begin
          nextState = scanFrom(req, 2, nocPkg::numPorts - 1);
        end
      end
      nocPkg::GrantE:
      begin
        if (!hold)
        begin
          nextState = scanFrom(req, 3, nocPkg::numPorts - 1);
        end
      end
      nocPkg::GrantW:
      begin
        if (!hold)
        begin
          nextState = scanFrom(req, 4, nocPkg::numPorts - 1);
        end
      end
      nocPkg::GrantS:
      begin
        if (!hold)
        begin
          nextState = scanFrom(req, 0, nocPkg::numPorts - 1);
        end
      end
      default:
      begin
        nextState = nocPkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= nocPkg::Idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  popOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("outputArbiter: more than one pop");

  popNeedsReq: assert property (@(posedge clk) disable iff (rst) (pop & ~req) == '0)
    else $error("outputArbiter: pop without request");

endmodule

//--- linkDriver.sv
`timescale 1ns/100ps

module linkDriver (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocPkg::flit_t [nocPkg::numPorts-1:0] head,
  input  nocPkg::portOneHot_t                  pop,
  output nocPkg::linkFlit_t                    outFlit,
  output logic                                 outValid
);

  nocPkg::portIdx_t srcIdx;
  logic             anyPop;

  // One-hot pop to input index
  always_comb
  begin
    srcIdx = '0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (pop[i])
      begin
        srcIdx = nocPkg::portIdx_t'(i);
      end
    end
  end

  assign anyPop = |pop;

  always_ff @(posedge clk)
  begin
    if (anyPop)
    begin
      outFlit.flit <= head[srcIdx];
      outFlit.src  <= srcIdx;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= anyPop;
    end
  end

endmodule

//--- nocOutPort.sv
`timescale 1ns/100ps

module nocOutPort #(
  parameter int FifoDepth = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocPkg::flit_t [nocPkg::numPorts-1:0] inFlit,
  input  nocPkg::portOneHot_t                  inValid,
  output nocPkg::linkFlit_t                    outFlit,
  output logic                                 outValid,
  output nocPkg::portOneHot_t                  overflow
);

  nocPkg::flit_t [nocPkg::numPorts-1:0] head;
  nocPkg::portOneHot_t                  req;
  nocPkg::portOneHot_t                  grantPop;

  // Input order Local, North, East, West, South
  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gInput
    flitFifo #(
      .FifoDepth (FifoDepth)
    ) uFifo (
      .clk      (clk),
      .rst      (rst),
      .wrFlit   (inFlit[i]),
      .wr       (inValid[i]),
      .pop      (grantPop[i]),
      .head     (head[i]),
      .notEmpty (req[i]),
      .overflow (overflow[i])
    );
  end

  outputArbiter uArbiter (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .head (head),
    .pop  (grantPop)
  );

  linkDriver uLink (
    .clk      (clk),
    .rst      (rst),
    .head     (head),
    .pop      (grantPop),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

//--- tbClock.sv
`timescale 1ns/100ps

module tbClock #(
  parameter int HalfPeriod  = 2,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #(HalfPeriod) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tbNocOutPort.sv
`timescale 1ns/100ps

module tbNocOutPort;

  localparam int NumPorts         = nocPkg::numPorts;
  localparam int NumPackets       = 50;
  // 3.5 flits per packet, 13.5 cycles apart on average
  localparam int MeanPacketCycles = 48;
  localparam int LatencyCycles    = 80;
  localparam int DrainCycles      = 120;
  localparam int CycleLimit       =
    (NumPackets * MeanPacketCycles + LatencyCycles + DrainCycles) * 3 / 2 + 100;
  localparam logic [31:0] LfsrTaps = 32'h80200003;

  logic                         clk;
  logic                         rst;
  nocPkg::flit_t [NumPorts-1:0] inFlit;
  nocPkg::portOneHot_t          inValid;
  nocPkg::linkFlit_t            outFlit;
  logic                         outValid;
  nocPkg::portOneHot_t          overflow;

  // Staged for the next rising edge, and the write the DUT just took
  nocPkg::flit_t [NumPorts-1:0] nextFlit;
  nocPkg::portOneHot_t          nextValid;
  nocPkg::flit_t [NumPorts-1:0] capFlit;
  nocPkg::portOneHot_t          capValid;

  nocPkg::flit_t       expQ [NumPorts][$];
  int                  latched [NumPorts];
  int                  runCount;
  int                  runLimit;
  // Output and queue history, one and two cycles back
  logic                v1;
  logic                v2;
  int                  s1;
  int                  s2;
  nocPkg::portOneHot_t held1;
  nocPkg::portOneHot_t held2;

  int          pktsLeft [NumPorts];
  int          flitsLeft [NumPorts];
  int          cooldown [NumPorts];
  logic        trafficOn;
  logic        outSeen;
  logic [31:0] lfsr;
  int          cycleCnt;
  int          runCycles = 0;
  int          checks;
  int          errors;

  tbClock uClock (
    .clk (clk),
    .rst (rst)
  );

  nocOutPort #(
    .FifoDepth (8)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .outFlit  (outFlit),
    .outValid (outValid),
    .overflow (overflow)
  );

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ LfsrTaps;
    return n;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    return v;
  endfunction

  // Walk backwards so the earliest port in circular order wins
  function automatic int firstHeld(input nocPkg::portOneHot_t held, input int first,
                                   input int span);
    int idx;
    int pick;
    pick = -1;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % NumPorts;
      if (held[idx])
        pick = idx;
    end
    return pick;
  endfunction

  function automatic logic pendingFlits();
    logic any;
    any = (capValid != '0);
    for (int p = 0; p < NumPorts; p++)
      if (expQ[p].size() != 0)
        any = 1'b1;
    return any;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (expected == actual)
    else
    begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("Error in cycle %0d: %s", cycleCnt, what);
    end
  endtask

  task automatic processCycle();
    nocPkg::linkFlit_t   got;
    nocPkg::flit_t       exp;
    nocPkg::portOneHot_t held;
    int                  src;
    int                  pick;
    logic                contExpected;
    logic                srcOk;
    for (int p = 0; p < NumPorts; p++)
      if (capValid[p])
        expQ[p].push_back(capFlit[p]);
    got     = outFlit;
    outSeen = outValid;
    src     = int'(got.src);
    srcOk   = (src < NumPorts);
    checkValue("overflow", 32'h0, 32'(overflow));
    if (v1)
    begin
      // Owner keeps the link while it holds flits and budget
      contExpected = held1[s1] && (runCount < runLimit);
      checkTrue(outValid == contExpected,
        $sformatf("port %0d tenure gave outValid %0b, model expects %0b",
                  s1, outValid, contExpected));
      if (outValid)
        checkValue("outFlit.src", 32'(s1), 32'(got.src));
    end
    else
    begin
      // Grant decided two cycles back, from the owner or from Idle
      pick = v2 ? firstHeld(held2, s2 + 1, NumPorts - 1) : firstHeld(held2, 0, NumPorts);
      checkValue("outValid", 32'(pick >= 0), 32'(outValid));
      if (outValid && pick >= 0)
        checkValue("outFlit.src", 32'(pick), 32'(got.src));
    end
    if (outValid)
    begin
      if (srcOk)
        srcOk = (expQ[src].size() != 0);
      checkTrue(srcOk, $sformatf("output from port %0d with no flit pending there", src));
      if (srcOk)
      begin
        exp = expQ[src].pop_front();
        checkValue("outFlit.flit.id", 32'(exp.id), 32'(got.flit.id));
        checkValue("outFlit.flit.payload", 32'(exp.payload), 32'(got.flit.payload));
        if (v1 && s1 == src)
          runCount++;
        else
        begin
          runCount = 1;
          runLimit = latched[src];
        end
        checkTrue(runCount <= runLimit,
          $sformatf("port %0d sent %0d flits in a row, length is %0d", src, runCount, runLimit));
        if (exp.id == nocPkg::FlitHeader)
          latched[src] = int'(nocPkg::length_t'(exp.payload));
      end
    end
    for (int p = 0; p < NumPorts; p++)
      held[p] = (expQ[p].size() != 0);
    v2    = v1;
    s2    = s1;
    held2 = held1;
    v1    = outValid && srcOk;
    s1    = src;
    held1 = held;
  endtask

  task automatic genTraffic();
    nocPkg::flit_t f;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (cooldown[p] != 0)
        cooldown[p]--;
      else if (flitsLeft[p] != 0 || pktsLeft[p] != 0)
      begin
        if (flitsLeft[p] == 0)
        begin
          f.id         = nocPkg::FlitHeader;
          f.payload    = {4'(randBits(4)), 12'(1 + randBits(2))};
          flitsLeft[p] = 1 + int'(randBits(2));
          pktsLeft[p]--;
        end
        else
        begin
          f.id      = (flitsLeft[p] == 1) ? nocPkg::FlitTail : nocPkg::FlitBody;
          f.payload = 16'(randBits(16));
          flitsLeft[p]--;
        end
        nextValid[p] = 1'b1;
        nextFlit[p]  = f;
        // Ten to seventeen cycles between flits of one port
        cooldown[p] = 9 + int'(randBits(3));
      end
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    cycleCnt++;
    inValid <= nextValid;
    inFlit  <= nextFlit;
    @(negedge clk);
    processCycle();
    capValid  = inValid;
    capFlit   = inFlit;
    nextValid = '0;
    if (trafficOn)
      genTraffic();
  endtask

  task automatic runLatency();
    nocPkg::flit_t f;
    int            quiet;
    for (int p = 0; p < NumPorts; p++)
    begin
      quiet = 0;
      while (quiet < 3)
      begin
        stepCycle();
        quiet = (outSeen || pendingFlits()) ? 0 : quiet + 1;
      end
      f.id         = nocPkg::FlitHeader;
      f.payload    = {4'(randBits(4)), 12'd1};
      nextValid[p] = 1'b1;
      nextFlit[p]  = f;
      stepCycle();
      for (int k = 1; k <= 3; k++)
      begin
        stepCycle();
        checkValue("outValid", 32'(k == 3), 32'(outSeen));
      end
    end
  endtask

  task automatic runTraffic();
    logic busy;
    for (int p = 0; p < NumPorts; p++)
    begin
      pktsLeft[p]  = NumPackets;
      flitsLeft[p] = 0;
      cooldown[p]  = int'(randBits(3));
    end
    trafficOn = 1'b1;
    busy      = 1'b1;
    while (busy)
    begin
      stepCycle();
      busy = 1'b0;
      for (int p = 0; p < NumPorts; p++)
        if (pktsLeft[p] != 0 || flitsLeft[p] != 0)
          busy = 1'b1;
    end
    trafficOn = 1'b0;
    repeat (DrainCycles) stepCycle();
    for (int p = 0; p < NumPorts; p++)
      checkTrue(expQ[p].size() == 0,
        $sformatf("port %0d still holds %0d flits after the drain", p, expQ[p].size()));
  endtask

  always @(posedge clk)
  begin
    runCycles <= runCycles + 1;
    if (runCycles == CycleLimit)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", runCycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial
  begin
    int errBase;
    inFlit    = '0;
    inValid   = '0;
    nextFlit  = '0;
    nextValid = '0;
    capFlit   = '0;
    capValid  = '0;
    lfsr      = 32'h62c9ffd1;
    trafficOn = 1'b0;
    outSeen   = 1'b0;
    v1        = 1'b0;
    v2        = 1'b0;
    s1        = 0;
    s2        = 0;
    held1     = '0;
    held2     = '0;
    runCount  = 0;
    runLimit  = 1;
    cycleCnt  = 0;
    checks    = 0;
    errors    = 0;
    // Length after reset
    for (int p = 0; p < NumPorts; p++)
      latched[p] = 1;
    @(negedge clk);
    while (rst)
      @(negedge clk);
    errBase = errors;
    runLatency();
    $display("Latency test finished with %0d errors", errors - errBase);
    errBase = errors;
    runTraffic();
    $display("Traffic test finished with %0d errors", errors - errBase);
    $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycleCnt);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- nocOutPort.f
nocPkg.sv
flitFifo.sv
holdTimer.sv
outputArbiter.sv
linkDriver.sv
nocOutPort.sv
tbClock.sv
tbNocOutPort.sv

//--- build.sh
#!/bin/sh
# Compile and run the nocOutPort testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbNocOutPort \
  -f nocOutPort.f -o simNocOutPort > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simNocOutPort > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
exit 1
